//--- rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_e        alu_op,
    input  wire  [cpu_pkg::DATA_W-1:0]   src1,
    input  wire  [cpu_pkg::DATA_W-1:0]   src2,
    output logic [cpu_pkg::DATA_W-1:0]   result
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic              lt_signed;
    logic              lt_unsigned;
    logic [4:0]        shamt;

    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;
    assign shamt       = src1[4:0];  // Shift amount from src1.

    always_comb begin
        case (alu_op)
            ADD:     result = sum;
            SUB:     result = diff;
            SLT:     result = {{(DATA_W-1){1'b0}}, lt_signed};
            SLTU:    result = {{(DATA_W-1){1'b0}}, lt_unsigned};
            AND:     result = src1 & src2;
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            NOR:     result = ~(src1 | src2);
            SLL:     result = src2 << shamt;
            SRL:     result = src2 >> shamt;
            SRA:     result = $unsigned($signed(src2) >>> shamt);
            LUI:     result = {src2[15:0], 16'b0};
            default: result = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_ADDR_W = 6;  // Index from address bits 7:2.

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_LW,
        OP_SW
    } exe_op_e;

    // ALU function select.
    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA, LUI
    } alu_op_e;

    typedef struct packed {
        exe_op_e               op;
        logic                  src2_is_imm;  // Imm is sign-extended.
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [15:0]           imm;
        logic [DATA_W-1:0]     rs_value;
        logic [DATA_W-1:0]     rt_value;
        logic [DATA_W-1:0]     pc;
        logic [4:0]            sa;
    } ds_to_es_t;

    typedef struct packed {
        logic                  mem_re;
        logic                  mem_we;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;      // ALU, HI/LO or address.
        logic [DATA_W-1:0]     store_data;
        logic [DATA_W-1:0]     pc;
    } es_to_ms_t;

    // Writeback record.
    typedef struct packed {
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     value;
        logic [DATA_W-1:0]     pc;
    } ms_to_ws_t;

endpackage

`default_nettype wire

//--- rtl/divider.sv
`timescale 1ns/100ps
`default_nettype none

module divider (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         start,
    input  wire                         is_signed,
    input  wire  [cpu_pkg::DATA_W-1:0]  dividend,
    input  wire  [cpu_pkg::DATA_W-1:0]  divisor,
    output logic                        busy,
    output logic                        done,
    output logic [cpu_pkg::DATA_W-1:0]  quotient,
    output logic [cpu_pkg::DATA_W-1:0]  remainder
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, FIX} state_e;

    state_e                      state;
    logic [$clog2(DATA_W)-1:0]   count;
    logic [DATA_W-1:0]           quo;   // Dividend shifts out, quotient shifts in.
    logic [DATA_W-1:0]           rem;
    logic [DATA_W-1:0]           dvs;
    logic                        neg_q;
    logic                        neg_r;
    logic [DATA_W:0]             rem_shift;
    logic [DATA_W:0]             diff;

    assign rem_shift = {rem, quo[DATA_W-1]};
    assign diff      = rem_shift - {1'b0, dvs};  // Bit DATA_W is the borrow.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start) state <= RUN;
                RUN:     if (count == DATA_W - 1) state <= FIX;
                default: state <= IDLE;
            endcase
        end
    end

    // Operate on magnitudes.
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            quo   <= (is_signed && dividend[DATA_W-1]) ? -dividend : dividend;
            dvs   <= (is_signed && divisor[DATA_W-1]) ? -divisor : divisor;
            rem   <= '0;
            count <= '0;
            neg_q <= is_signed && (dividend[DATA_W-1] ^ divisor[DATA_W-1]);
            neg_r <= is_signed && dividend[DATA_W-1];
        end else if (state == RUN) begin
            count <= count + 1'b1;
            if (!diff[DATA_W]) begin
                rem <= diff[DATA_W-1:0];
                quo <= {quo[DATA_W-2:0], 1'b1};
            end else begin
                rem <= rem_shift[DATA_W-1:0];  // Restore.
                quo <= {quo[DATA_W-2:0], 1'b0};
            end
        end
    end

    assign busy      = (state != IDLE);
    assign done      = (state == FIX);
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;  // Takes the dividend's sign.

    assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("divider start while busy");

endmodule

`default_nettype wire

//--- rtl/exe_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module exe_pipe (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire cpu_pkg::ds_to_es_t     in_bus,
    output logic                        out_valid,
    input  wire                         out_ready,
    output cpu_pkg::ms_to_ws_t          out_bus
);
    import cpu_pkg::*;

    logic      es_valid;
    logic      ms_ready;
    es_to_ms_t es_bus;

    exe_stage exe_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_bus   (in_bus),
        .es_valid (es_valid),
        .ms_ready (ms_ready),
        .es_bus   (es_bus)
    );

    mem_stage mem_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .es_valid  (es_valid),
        .ms_ready  (ms_ready),
        .es_bus    (es_bus),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bus   (out_bus)
    );

endmodule

`default_nettype wire

//--- rtl/exe_stage.sv
`timescale 1ns/100ps
`default_nettype none

module exe_stage (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire cpu_pkg::ds_to_es_t     in_bus,
    output logic                        es_valid,
    input  wire                         ms_ready,
    output cpu_pkg::es_to_ms_t          es_bus
);
    import cpu_pkg::*;

    ds_to_es_t             es_reg;
    logic                  es_full;
    logic                  ready_go;
    logic                  leave;
    logic                  accept;
    alu_op_e               alu_op;
    logic                  is_shift;
    logic                  is_mem;
    logic                  is_div;
    logic                  mul_signed;
    logic [DATA_W-1:0]     imm_sext;
    logic [DATA_W-1:0]     src1;
    logic [DATA_W-1:0]     src2;
    logic [DATA_W-1:0]     alu_result;
    logic [2*DATA_W-1:0]   mul_prod;
    logic [DATA_W-1:0]     hi;
    logic [DATA_W-1:0]     lo;
    logic                  div_start;
    logic                  div_started;
    logic                  div_fin;
    logic                  div_done;
    logic [DATA_W-1:0]     div_quo;
    logic [DATA_W-1:0]     div_rem;

    assign is_shift   = es_reg.op inside {OP_SLL, OP_SRL, OP_SRA};
    assign is_mem     = es_reg.op inside {OP_LW, OP_SW};
    assign is_div     = es_reg.op inside {OP_DIV, OP_DIVU};
    assign mul_signed = (es_reg.op == OP_MULT);

    // A divide holds the stage until the divider finishes.
    assign ready_go = !is_div || div_fin || div_done;
    assign es_valid = es_full && ready_go;
    assign leave    = es_valid && ms_ready;
    assign in_ready = !es_full || leave;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_full     <= 1'b0;
            div_started <= 1'b0;
            div_fin     <= 1'b0;
        end else begin
            if (in_ready) es_full <= in_valid;
            if (accept) begin
                div_started <= 1'b0;
                div_fin     <= 1'b0;
            end else begin
                if (div_start) div_started <= 1'b1;
                if (div_done) div_fin <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) es_reg <= in_bus;
    end

    always_comb begin
        case (es_reg.op)
            OP_SUB:  alu_op = SUB;
            OP_SLT:  alu_op = SLT;
            OP_SLTU: alu_op = SLTU;
            OP_AND:  alu_op = AND;
            OP_OR:   alu_op = OR;
            OP_XOR:  alu_op = XOR;
            OP_NOR:  alu_op = NOR;
            OP_SLL:  alu_op = SLL;
            OP_SRL:  alu_op = SRL;
            OP_SRA:  alu_op = SRA;
            OP_LUI:  alu_op = LUI;
            default: alu_op = ADD;  // Also the LW/SW address.
        endcase
    end

    assign imm_sext = {{(DATA_W-16){es_reg.imm[15]}}, es_reg.imm};
    assign src1     = is_shift ? {{(DATA_W-5){1'b0}}, es_reg.sa} : es_reg.rs_value;
    assign src2     = (es_reg.src2_is_imm || is_mem) ? imm_sext : es_reg.rt_value;

    alu alu_inst (
        .alu_op (alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    assign mul_prod = $signed({mul_signed & es_reg.rs_value[DATA_W-1], es_reg.rs_value}) *
                      $signed({mul_signed & es_reg.rt_value[DATA_W-1], es_reg.rt_value});

    assign div_start = es_full && is_div && !div_started;

    divider divider_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (es_reg.op == OP_DIV),
        .dividend  (es_reg.rs_value),
        .divisor   (es_reg.rt_value),
        .busy      (),
        .done      (div_done),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

    always_ff @(posedge clk) begin
        if (div_done) begin
            hi <= div_rem;
            lo <= div_quo;
        end else if (leave) begin
            case (es_reg.op)
                OP_MULT, OP_MULTU: begin
                    hi <= mul_prod[2*DATA_W-1:DATA_W];
                    lo <= mul_prod[DATA_W-1:0];
                end
                OP_MTHI: hi <= es_reg.rs_value;
                OP_MTLO: lo <= es_reg.rs_value;
                default: ;
            endcase
        end
    end

    always_comb begin
        es_bus.mem_re     = (es_reg.op == OP_LW);
        es_bus.mem_we     = (es_reg.op == OP_SW);
        es_bus.gr_we      = es_reg.gr_we;
        es_bus.dest       = es_reg.dest;
        es_bus.store_data = es_reg.rt_value;
        es_bus.pc         = es_reg.pc;
        case (es_reg.op)
            OP_MFHI: es_bus.result = hi;
            OP_MFLO: es_bus.result = lo;
            default: es_bus.result = alu_result;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        es_valid && !ms_ready |=> es_valid && $stable(es_bus))
        else $error("es_bus changed under back-pressure");

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         es_valid,
    output logic                        ms_ready,
    input  wire cpu_pkg::es_to_ms_t     es_bus,
    output logic                        out_valid,
    input  wire                         out_ready,
    output cpu_pkg::ms_to_ws_t          out_bus
);
    import cpu_pkg::*;

    logic [DATA_W-1:0]      dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] index;
    logic                   accept;
    logic                   ms_full;
    ms_to_ws_t              ms_rec;
    logic                   ms_load;
    logic [DATA_W-1:0]      load_data;

    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = '0;
        end
    end

    assign index     = es_bus.result[DMEM_ADDR_W+1:2];  // Word address.
    assign ms_ready  = !ms_full || out_ready;
    assign accept    = es_valid && ms_ready;
    assign out_valid = ms_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_full <= 1'b0;
        end else if (ms_ready) begin
            ms_full <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ms_rec.gr_we <= es_bus.gr_we;
            ms_rec.dest  <= es_bus.dest;
            ms_rec.value <= es_bus.result;
            ms_rec.pc    <= es_bus.pc;
            ms_load      <= es_bus.mem_re;
        end
    end

    // Synchronous RAM, read and write on acceptance.
    always @(posedge clk) begin
        if (accept) begin
            if (es_bus.mem_we) dmem[index] <= es_bus.store_data;
            if (es_bus.mem_re) load_data <= dmem[index];
        end
    end

    always_comb begin
        out_bus = ms_rec;
        if (ms_load) out_bus.value = load_data;
    end

    assert property (@(posedge clk) disable iff (reset)
        es_valid |-> !(es_bus.mem_re && es_bus.mem_we))
        else $error("load and store in one instruction");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds and runs the exe_pipe testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module exe_pipe_tb -Mdir obj_dir -o sim_exe_pipe
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/sim_exe_pipe > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status."
    exit 1
fi
echo "Simulation finished without failures."
exit 0

//--- sim.f
+incdir+sim
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/divider.sv
rtl/exe_stage.sv
rtl/mem_stage.sv
rtl/exe_pipe.sv
sim/exe_pipe_tb.sv

//--- sim/exe_pipe_table.svh
// Columns: op, rs, rt, imm, use_imm, sa, dest, gr_we, expected writeback value.
// Records with gr_we low carry no checked value.
function automatic void build_table();
    add_entry(OP_ADD,   32'h00000007, 32'h00000005, 16'h0000, 0, 0,  1, 1, 32'h0000000c);
    add_entry(OP_ADD,   32'h00000010, 32'h00000000, 16'hfffc, 1, 0,  2, 1, 32'h0000000c);
    add_entry(OP_SUB,   32'h00000005, 32'h00000007, 16'h0000, 0, 0,  3, 1, 32'hfffffffe);
    add_entry(OP_SLT,   32'hffffffff, 32'h00000001, 16'h0000, 0, 0,  4, 1, 32'h00000001);
    add_entry(OP_SLTU,  32'hffffffff, 32'h00000001, 16'h0000, 0, 0,  5, 1, 32'h00000000);
    add_entry(OP_SLTU,  32'h00000003, 32'h00000000, 16'hffff, 1, 0,  6, 1, 32'h00000001);
    add_entry(OP_AND,   32'hf0f0f0f0, 32'hff00ff00, 16'h0000, 0, 0,  7, 1, 32'hf000f000);
    add_entry(OP_AND,   32'h1234abcd, 32'h00000000, 16'h8000, 1, 0,  8, 1, 32'h12348000);
    add_entry(OP_OR,    32'h0f0f0000, 32'h000000ff, 16'h0000, 0, 0,  9, 1, 32'h0f0f00ff);
    add_entry(OP_XOR,   32'haaaa5555, 32'hffff0000, 16'h0000, 0, 0, 10, 1, 32'h55555555);
    add_entry(OP_NOR,   32'h0000ffff, 32'h00ff0000, 16'h0000, 0, 0, 11, 1, 32'hff000000);
    add_entry(OP_SLL,   32'hffffffff, 32'h00000003, 16'h0000, 0, 4, 12, 1, 32'h00000030);
    add_entry(OP_SRL,   32'h00000000, 32'h80000000, 16'h0000, 0, 31, 13, 1, 32'h00000001);
    add_entry(OP_SRA,   32'h00000000, 32'h80000000, 16'h0000, 0, 4, 14, 1, 32'hf8000000);
    add_entry(OP_LUI,   32'h00000000, 32'h00000000, 16'habcd, 1, 0, 15, 1, 32'habcd0000);
    // Multiply, then HI/LO moves.
    add_entry(OP_MULT,  32'h80000000, 32'hfffffffe, 16'h0000, 0, 0,  0, 0, 32'h00000000);
    add_entry(OP_MFHI,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 16, 1, 32'h00000001);
    add_entry(OP_MFLO,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 17, 1, 32'h00000000);
    add_entry(OP_MULTU, 32'hffffffff, 32'h00000002, 16'h0000, 0, 0,  0, 0, 32'h00000000);
    add_entry(OP_MFHI,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 18, 1, 32'h00000001);
    add_entry(OP_MFLO,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 19, 1, 32'hfffffffe);
    add_entry(OP_MTHI,  32'hdeadbeef, 32'h00000000, 16'h0000, 0, 0,  0, 0, 32'h00000000);
    add_entry(OP_MTLO,  32'h0badf00d, 32'h00000000, 16'h0000, 0, 0,  0, 0, 32'h00000000);
    add_entry(OP_MFHI,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 20, 1, 32'hdeadbeef);
    add_entry(OP_MFLO,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 21, 1, 32'h0badf00d);
    // Divide: -17 / 5 and 0xffffffff / 16.
    add_entry(OP_DIV,   32'hffffffef, 32'h00000005, 16'h0000, 0, 0,  0, 0, 32'h00000000);
    add_entry(OP_MFLO,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 22, 1, 32'hfffffffd);
    add_entry(OP_MFHI,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 23, 1, 32'hfffffffe);
    add_entry(OP_DIVU,  32'hffffffff, 32'h00000010, 16'h0000, 0, 0,  0, 0, 32'h00000000);
    add_entry(OP_ADD,   32'h00000001, 32'h00000002, 16'h0000, 0, 0, 26, 1, 32'h00000003);
    add_entry(OP_MFLO,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 24, 1, 32'h0fffffff);
    add_entry(OP_MFHI,  32'h00000000, 32'h00000000, 16'h0000, 0, 0, 25, 1, 32'h0000000f);
    // Stores, then loads back.
    add_entry(OP_SW,    32'h00000040, 32'hcafef00d, 16'h0000, 1, 0,  0, 0, 32'h00000000);
    add_entry(OP_SW,    32'h00000040, 32'h12345678, 16'h0004, 1, 0,  0, 0, 32'h00000000);
    add_entry(OP_SW,    32'h00000040, 32'ha5a5a5a5, 16'hfffc, 1, 0,  0, 0, 32'h00000000);
    add_entry(OP_LW,    32'h00000040, 32'h00000000, 16'h0004, 1, 0, 27, 1, 32'h12345678);
    add_entry(OP_LW,    32'h00000044, 32'h00000000, 16'hfff8, 1, 0, 28, 1, 32'ha5a5a5a5);
    add_entry(OP_LW,    32'h00000040, 32'h00000000, 16'h0000, 1, 0, 29, 1, 32'hcafef00d);
    add_entry(OP_LW,    32'h00000080, 32'h00000000, 16'h0000, 1, 0, 30, 1, 32'h00000000);
endfunction

//--- sim/exe_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exe_pipe_tb;
    import cpu_pkg::*;

    localparam int                TIMEOUT_CYCLES = 200;
    localparam logic [DATA_W-1:0] PC_BASE        = 32'h0000_1000;

    typedef struct packed {
        exe_op_e           op;
        logic [DATA_W-1:0] rs;
        logic [DATA_W-1:0] rt;
        logic [15:0]       imm;
        logic              use_imm;
        logic [4:0]        sa;
        logic [4:0]        dest;
        logic              gr_we;
        logic [DATA_W-1:0] value;  // Checked only when gr_we is high.
    } entry_t;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    ds_to_es_t in_bus;
    logic      out_valid;
    logic      out_ready;
    ms_to_ws_t out_bus;
    entry_t    stim_table [$];
    int        seed;
    int        ready_seed;
    int        rec_count;

    exe_pipe exe_pipe_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bus    (in_bus),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bus   (out_bus)
    );

    always #2 clk = ~clk;

    // Random output stalls, roughly one cycle in four.
    always @(posedge clk) begin
        if (reset) out_ready <= 1'b0;
        else out_ready <= ($unsigned($random(ready_seed)) % 4) != 0;
    end

    // Counts every writeback transfer.
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) rec_count++;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped after an error.");
    endtask

    function automatic void add_entry(input exe_op_e op, input logic [DATA_W-1:0] rs,
                                      input logic [DATA_W-1:0] rt, input logic [15:0] imm,
                                      input int use_imm, input int sa, input int dest,
                                      input int gr_we, input logic [DATA_W-1:0] value);
        entry_t e;
        e.op      = op;
        e.rs      = rs;
        e.rt      = rt;
        e.imm     = imm;
        e.use_imm = use_imm[0];
        e.sa      = sa[4:0];
        e.dest    = dest[4:0];
        e.gr_we   = gr_we[0];
        e.value   = value;
        stim_table.push_back(e);
    endfunction

    `include "exe_pipe_table.svh"

    function automatic ds_to_es_t bus_for(input int idx);
        ds_to_es_t b;
        b.op          = stim_table[idx].op;
        b.src2_is_imm = stim_table[idx].use_imm;
        b.gr_we       = stim_table[idx].gr_we;
        b.dest        = stim_table[idx].dest;
        b.imm         = stim_table[idx].imm;
        b.rs_value    = stim_table[idx].rs;
        b.rt_value    = stim_table[idx].rt;
        b.pc          = PC_BASE + (idx << 2);
        b.sa          = stim_table[idx].sa;
        return b;
    endfunction

    task automatic wait_input_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            assert (waited < TIMEOUT_CYCLES) else
                stop_with_failure("Timeout: the DUT accepted no input within 200 cycles.");
            @(posedge clk);
        end
    endtask

    task automatic wait_output_transfer();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!(out_valid && out_ready)) begin
            waited++;
            assert (waited < TIMEOUT_CYCLES) else
                stop_with_failure("Timeout: no writeback record arrived within 200 cycles.");
            @(posedge clk);
        end
    endtask

    task automatic drive_inputs();
        int gap;
        for (int i = 0; i < stim_table.size(); i++) begin
            gap = $unsigned($random(seed)) % 4;
            if (gap > 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_bus   <= bus_for(i);
            wait_input_accept();
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_outputs();
        entry_t            e;
        logic [DATA_W-1:0] exp_pc;
        for (int i = 0; i < stim_table.size(); i++) begin
            wait_output_transfer();
            e      = stim_table[i];
            exp_pc = PC_BASE + (i << 2);
            assert (out_bus.pc == exp_pc) else
                stop_with_failure($sformatf("MISMATCH at time %0t: record %0d pc %h, expected %h",
                                            $time, i, out_bus.pc, exp_pc));
            assert (out_bus.gr_we == e.gr_we && out_bus.dest == e.dest) else
                stop_with_failure($sformatf("MISMATCH at time %0t: record %0d gr_we/dest %b/%0d",
                                            $time, i, out_bus.gr_we, out_bus.dest));
            assert (!e.gr_we || out_bus.value == e.value) else
                stop_with_failure($sformatf("MISMATCH at time %0t: record %0d value %h, expected %h",
                                            $time, i, out_bus.value, e.value));
        end
        // Nothing more may come out.
        repeat (8) begin
            @(posedge clk);
            assert (!out_valid) else
                stop_with_failure("The DUT produced more records than instructions were sent.");
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_bus     = '0;
        out_ready  = 1'b0;
        seed       = 51521;
        ready_seed = 51521;
        rec_count  = 0;
        build_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        fork
            drive_inputs();
            check_outputs();
        join
        if (rec_count == stim_table.size()) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_failure("The record count does not match the table length.");
        end
    end

endmodule

`default_nettype wire
